//--- common/opstage_pkg.sv
// Shared widths, select codes, opcodes and EX states, referenced by scoped names from all blocks
`default_nettype none

package opstage_pkg;

	//////////////////////////////////////////////////////////////////////
	// Data and register file geometry
	//////////////////////////////////////////////////////////////////////
	localparam int DATA_W = 32;
	typedef logic [DATA_W-1:0] word_t;

	localparam int REG_N = 16;
	typedef logic [$clog2(REG_N)-1:0] reg_idx_t;

	//////////////////////////////////////////////////////////////////////
	// Operand source selects
	//////////////////////////////////////////////////////////////////////
	typedef logic [1:0] sel_t;
	localparam sel_t SEL_RF      = 2'd0;
	// Immediate is only meaningful for operand B
	localparam sel_t SEL_IMM     = 2'd1;
	localparam sel_t SEL_EX_FORW = 2'd2;
	localparam sel_t SEL_WB_FORW = 2'd3;

	// ALU opcodes as delivered by the decoder
	typedef logic [2:0] op_t;
	localparam op_t OP_ADD = 3'd0;
	localparam op_t OP_SUB = 3'd1;
	localparam op_t OP_AND = 3'd2;
	localparam op_t OP_OR  = 3'd3;
	localparam op_t OP_XOR = 3'd4;
	localparam op_t OP_MUL = 3'd5;

	// EX sequencer, EX_MUL while a multiply still owes cycles
	typedef enum logic {EX_RUN, EX_MUL} ex_state_t;

endpackage

`default_nettype wire

//--- src/reg_file.sv
// General purpose register file, two combinational read ports and one write port from WB
`default_nettype none

module reg_file (
	input wire clk,
	input wire rst,
	input wire opstage_pkg::reg_idx_t ra,
	input wire opstage_pkg::reg_idx_t rb,
	input wire we,
	input wire opstage_pkg::reg_idx_t wa,
	input wire opstage_pkg::word_t wd,
	output opstage_pkg::word_t rf_dataa,
	output opstage_pkg::word_t rf_datab
);

	opstage_pkg::word_t regs [opstage_pkg::REG_N];

	// Write port, r0 is never written
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < opstage_pkg::REG_N; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wa != '0)) begin
			regs[wa] <= wd;
		end
	end

	// Read ports
	// No write bypass here, same-cycle WB data reaches ID through forwarding
	assign rf_dataa = (ra == '0) ? '0 : regs[ra];
	assign rf_datab = (rb == '0) ? '0 : regs[rb];

endmodule

`default_nettype wire

//--- operands/forward_sel.sv
// Picks the source of each operand in ID by comparing source indices to EX and WB destinations
`default_nettype none

module forward_sel (
	input wire opstage_pkg::reg_idx_t ra,
	input wire opstage_pkg::reg_idx_t rb,
	input wire use_imm,
	input wire ex_valid,
	input wire opstage_pkg::reg_idx_t ex_rd,
	input wire wb_valid,
	input wire opstage_pkg::reg_idx_t wb_rd,
	output opstage_pkg::sel_t sel_a,
	output opstage_pkg::sel_t sel_b
);

	// Hazard hits per source and stage
	logic a_ex_hit;
	logic a_wb_hit;
	logic b_ex_hit;
	logic b_wb_hit;

	// r0 is hardwired so it never needs a forward
	assign a_ex_hit = (ra != '0) && ex_valid && (ra == ex_rd);
	assign a_wb_hit = (ra != '0) && wb_valid && (ra == wb_rd);
	assign b_ex_hit = (rb != '0) && ex_valid && (rb == ex_rd);
	assign b_wb_hit = (rb != '0) && wb_valid && (rb == wb_rd);

	// EX holds the younger result so it wins over WB
	assign sel_a = a_ex_hit ? opstage_pkg::SEL_EX_FORW :
		a_wb_hit ? opstage_pkg::SEL_WB_FORW :
		opstage_pkg::SEL_RF;

	// Immediate overrides any register match on B
	always_comb begin
		if (use_imm) begin
			sel_b = opstage_pkg::SEL_IMM;
		end else if (b_ex_hit) begin
			sel_b = opstage_pkg::SEL_EX_FORW;
		end else if (b_wb_hit) begin
			sel_b = opstage_pkg::SEL_WB_FORW;
		end else begin
			sel_b = opstage_pkg::SEL_RF;
		end
	end

endmodule

`default_nettype wire

//--- operands/operand_mux.sv
// Operand muxes and ID/EX operand registers with save-on-freeze, instantiated once in the top level
`default_nettype none

module operand_mux (
	input wire clk,
	input wire rst,
	input wire id_freeze,
	input wire ex_freeze,
	input wire opstage_pkg::word_t rf_dataa,
	input wire opstage_pkg::word_t rf_datab,
	input wire opstage_pkg::word_t ex_forw,
	input wire opstage_pkg::word_t wb_forw,
	input wire opstage_pkg::word_t simm,
	input wire opstage_pkg::sel_t sel_a,
	input wire opstage_pkg::sel_t sel_b,
	output opstage_pkg::word_t operand_a,
	output opstage_pkg::word_t operand_b
);

	opstage_pkg::word_t muxed_a;
	opstage_pkg::word_t muxed_b;
	// Set once operands were taken during an ID-only freeze
	logic saved;

	//////////////////////////////////////////////////////////////////////
	// Source muxes
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (sel_a)
			opstage_pkg::SEL_EX_FORW: muxed_a = ex_forw;
			opstage_pkg::SEL_WB_FORW: muxed_a = wb_forw;
			// SEL_IMM never shows up on A
			default: muxed_a = rf_dataa;
		endcase
	end

	always_comb begin
		case (sel_b)
			opstage_pkg::SEL_IMM:     muxed_b = simm;
			opstage_pkg::SEL_EX_FORW: muxed_b = ex_forw;
			opstage_pkg::SEL_WB_FORW: muxed_b = wb_forw;
			default: muxed_b = rf_datab;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Operand registers
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			operand_a <= '0;
			operand_b <= '0;
			saved <= 1'b0;
		end else if (!ex_freeze && !id_freeze) begin
			// Instruction accepted, always take fresh operands
			operand_a <= muxed_a;
			operand_b <= muxed_b;
			saved <= 1'b0;
		end else if (!ex_freeze && !saved) begin
			// ID held while EX moves on, grab once then hold
			operand_a <= muxed_a;
			operand_b <= muxed_b;
			saved <= 1'b1;
		end
	end

	// Forwarded sources must land in the operand register on accept
	assert property (@(posedge clk) disable iff (rst)
		(!ex_freeze && !id_freeze && sel_a == opstage_pkg::SEL_EX_FORW)
		|=> (operand_a == $past(ex_forw)));
	assert property (@(posedge clk) disable iff (rst)
		(!ex_freeze && !id_freeze && sel_a == opstage_pkg::SEL_WB_FORW)
		|=> (operand_a == $past(wb_forw)));
	assert property (@(posedge clk) disable iff (rst)
		(!ex_freeze && !id_freeze && sel_b == opstage_pkg::SEL_IMM)
		|=> (operand_b == $past(simm)));

	// Save flag may only rise across a cycle where EX was running
	assert property (@(posedge clk) disable iff (rst)
		(ex_freeze && !saved) |=> !saved);

endmodule

`default_nettype wire

//--- src/pipe_ctrl.sv
// Pipeline control for EX and WB, multiply sequencing and freeze generation
`default_nettype none

module pipe_ctrl #(
	// Cycles a multiply spends in EX, at least 2
	parameter int MUL_CYCLES = 3
) (
	input wire clk,
	input wire rst,
	input wire instr_valid,
	input wire opstage_pkg::op_t op,
	input wire opstage_pkg::reg_idx_t rd,
	input wire ex_hold,
	output logic id_freeze,
	output logic ex_freeze,
	output logic ex_valid,
	output opstage_pkg::op_t ex_op,
	output opstage_pkg::reg_idx_t ex_rd,
	output logic wb_valid,
	output opstage_pkg::reg_idx_t wb_rd
);

	localparam int CNT_W = $clog2(MUL_CYCLES);

	opstage_pkg::ex_state_t ex_state;
	logic [CNT_W-1:0] mul_cnt;
	logic accept;

	// Freezes
	assign ex_freeze = ex_hold || (ex_state == opstage_pkg::EX_MUL);
	assign id_freeze = ex_freeze || !instr_valid;
	assign accept = !id_freeze;

	//////////////////////////////////////////////////////////////////////
	// EX control register, bubble when ID has nothing to give
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
			ex_op <= opstage_pkg::OP_ADD;
			ex_rd <= '0;
		end else if (!ex_freeze) begin
			ex_valid <= accept;
			if (accept) begin
				ex_op <= op;
				ex_rd <= rd;
			end
		end
	end

	// Multiply sequencer
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_state <= opstage_pkg::EX_RUN;
			mul_cnt <= '0;
		end else begin
			case (ex_state)
				opstage_pkg::EX_RUN: begin
					if (accept && (op == opstage_pkg::OP_MUL)) begin
						ex_state <= opstage_pkg::EX_MUL;
						mul_cnt <= CNT_W'(MUL_CYCLES - 1);
					end
				end
				opstage_pkg::EX_MUL: begin
					// Count stops under back-pressure
					if (!ex_hold) begin
						mul_cnt <= mul_cnt - 1'b1;
						if (mul_cnt == CNT_W'(1)) begin
							ex_state <= opstage_pkg::EX_RUN;
						end
					end
				end
				default: ex_state <= opstage_pkg::EX_RUN;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// WB control register, one pulse per retired instruction
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
			wb_rd <= '0;
		end else if (ex_freeze) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= ex_valid;
			wb_rd <= ex_rd;
		end
	end

	// A frozen EX retires nothing
	assert property (@(posedge clk) disable iff (rst) ex_freeze |=> !wb_valid);

	// Multiply state is only entered for a live multiply in EX
	assert property (@(posedge clk) disable iff (rst)
		$rose(ex_state == opstage_pkg::EX_MUL)
		|-> (ex_valid && (ex_op == opstage_pkg::OP_MUL)));

endmodule

`default_nettype wire

//--- src/exec_unit.sv
// EX stage datapath with the ALU, the multi-cycle product register and the WB result register
`default_nettype none

module exec_unit (
	input wire clk,
	input wire rst,
	input wire ex_freeze,
	input wire opstage_pkg::op_t ex_op,
	input wire opstage_pkg::word_t operand_a,
	input wire opstage_pkg::word_t operand_b,
	output opstage_pkg::word_t ex_forw,
	output opstage_pkg::word_t wb_forw
);

	opstage_pkg::word_t prod;
	// Product already taken for the multiply now in EX
	logic mul_busy;

	//////////////////////////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (ex_op)
			opstage_pkg::OP_ADD: ex_forw = operand_a + operand_b;
			opstage_pkg::OP_SUB: ex_forw = operand_a - operand_b;
			opstage_pkg::OP_AND: ex_forw = operand_a & operand_b;
			opstage_pkg::OP_OR:  ex_forw = operand_a | operand_b;
			opstage_pkg::OP_XOR: ex_forw = operand_a ^ operand_b;
			// Only read once EX unfreezes, by then prod holds the result
			opstage_pkg::OP_MUL: ex_forw = prod;
			default: ex_forw = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Multiplier
	//////////////////////////////////////////////////////////////////////
	// Busy from the first frozen cycle until EX moves
	always_ff @(posedge clk) begin
		if (rst) begin
			mul_busy <= 1'b0;
		end else if (!ex_freeze) begin
			mul_busy <= 1'b0;
		end else if (ex_op == opstage_pkg::OP_MUL) begin
			mul_busy <= 1'b1;
		end
	end

	// Lower 32 bits of the product
	// operands stay put while EX is frozen
	always_ff @(posedge clk) begin
		if ((ex_op == opstage_pkg::OP_MUL) && !mul_busy) begin
			prod <= operand_a * operand_b;
		end
	end

	// WB result register
	always_ff @(posedge clk) begin
		if (!ex_freeze) begin
			wb_forw <= ex_forw;
		end
	end

endmodule

`default_nettype wire

//--- src/opstage_top.sv
// Top level of the operand stage, wires ID, EX and WB blocks and exposes instruction and WB ports
`default_nettype none

module opstage_top #(
	parameter int MUL_CYCLES = 3
) (
	input wire clk,
	input wire rst,
	input wire instr_valid,
	input wire opstage_pkg::op_t op,
	input wire opstage_pkg::reg_idx_t rd,
	input wire opstage_pkg::reg_idx_t ra,
	input wire opstage_pkg::reg_idx_t rb,
	input wire opstage_pkg::word_t imm,
	input wire use_imm,
	input wire ex_hold,
	output logic stall,
	output logic wb_valid,
	output opstage_pkg::reg_idx_t wb_rd,
	output opstage_pkg::word_t wb_data
);

	// ID side
	opstage_pkg::word_t rf_dataa;
	opstage_pkg::word_t rf_datab;
	opstage_pkg::sel_t sel_a;
	opstage_pkg::sel_t sel_b;
	opstage_pkg::word_t operand_a;
	opstage_pkg::word_t operand_b;
	// Control
	logic id_freeze;
	logic ex_freeze;
	logic ex_valid;
	opstage_pkg::op_t ex_op;
	opstage_pkg::reg_idx_t ex_rd;
	// Results
	opstage_pkg::word_t ex_forw;
	opstage_pkg::word_t wb_forw;

	reg_file u_reg_file (
		.clk(clk), .rst(rst), .ra(ra), .rb(rb),
		.we(wb_valid), .wa(wb_rd), .wd(wb_forw),
		.rf_dataa(rf_dataa), .rf_datab(rf_datab)
	);

	forward_sel u_forward_sel (
		.ra(ra), .rb(rb), .use_imm(use_imm),
		.ex_valid(ex_valid), .ex_rd(ex_rd),
		.wb_valid(wb_valid), .wb_rd(wb_rd),
		.sel_a(sel_a), .sel_b(sel_b)
	);

	operand_mux u_operand_mux (
		.clk(clk), .rst(rst), .id_freeze(id_freeze), .ex_freeze(ex_freeze),
		.rf_dataa(rf_dataa), .rf_datab(rf_datab),
		.ex_forw(ex_forw), .wb_forw(wb_forw), .simm(imm),
		.sel_a(sel_a), .sel_b(sel_b),
		.operand_a(operand_a), .operand_b(operand_b)
	);

	pipe_ctrl #(.MUL_CYCLES(MUL_CYCLES)) u_pipe_ctrl (
		.clk(clk), .rst(rst), .instr_valid(instr_valid), .op(op), .rd(rd),
		.ex_hold(ex_hold), .id_freeze(id_freeze), .ex_freeze(ex_freeze),
		.ex_valid(ex_valid), .ex_op(ex_op), .ex_rd(ex_rd),
		.wb_valid(wb_valid), .wb_rd(wb_rd)
	);

	exec_unit u_exec_unit (
		.clk(clk), .rst(rst), .ex_freeze(ex_freeze), .ex_op(ex_op),
		.operand_a(operand_a), .operand_b(operand_b),
		.ex_forw(ex_forw), .wb_forw(wb_forw)
	);

	// Source must hold its fields while EX is frozen
	assign stall = ex_freeze;
	assign wb_data = wb_forw;

endmodule

`default_nettype wire

//--- tests/tb_opstage.sv
// Self-checking testbench for the operand stage, run through list.f with the top module tb_opstage
`default_nettype none

module tb_opstage;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MUL_CYCLES = 3;
	// Longest any single wait may last, in cycles
	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic rst;
	logic instr_valid;
	opstage_pkg::op_t op;
	opstage_pkg::reg_idx_t rd;
	opstage_pkg::reg_idx_t ra;
	opstage_pkg::reg_idx_t rb;
	opstage_pkg::word_t imm;
	logic use_imm;
	logic ex_hold;
	logic stall;
	logic wb_valid;
	opstage_pkg::reg_idx_t wb_rd;
	opstage_pkg::word_t wb_data;

	// Architectural register model
	opstage_pkg::word_t model_rf [opstage_pkg::REG_N];
	// Results owed by the DUT, oldest first
	opstage_pkg::reg_idx_t exp_rd_q [$];
	opstage_pkg::word_t exp_data_q [$];

	int errors;
	int checks;
	int issued;
	// Stalled cycles seen by the last issued instruction
	int stall_cycles;
	logic hold_mode;

	opstage_top #(.MUL_CYCLES(MUL_CYCLES)) DUT (
		.clk(clk), .rst(rst), .instr_valid(instr_valid), .op(op), .rd(rd),
		.ra(ra), .rb(rb), .imm(imm), .use_imm(use_imm), .ex_hold(ex_hold),
		.stall(stall), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
	);

	always #4 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////
	function automatic opstage_pkg::word_t alu_ref(input opstage_pkg::op_t f_op,
		input opstage_pkg::word_t a, input opstage_pkg::word_t b);
		logic [63:0] full;
		full = 64'(a) * 64'(b);
		case (f_op)
			opstage_pkg::OP_ADD: return a + b;
			opstage_pkg::OP_SUB: return a - b;
			opstage_pkg::OP_AND: return a & b;
			opstage_pkg::OP_OR:  return a | b;
			opstage_pkg::OP_XOR: return a ^ b;
			// Low word of the full product
			opstage_pkg::OP_MUL: return full[31:0];
			default: return '0;
		endcase
	endfunction

	// r0 reads zero whatever was written
	function automatic opstage_pkg::word_t model_read(input opstage_pkg::reg_idx_t idx);
		return (idx == '0) ? '0 : model_rf[idx];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Summary: %0d instructions, %0d checks, %0d errors", issued, checks, errors + 1);
		$display("Test FAILED");
		$finish;
	endtask

	// One clock edge, back-pressure redrawn when enabled
	task automatic tick();
		@(posedge clk);
		if (hold_mode) begin
			ex_hold <= ($urandom_range(3, 0) == 0);
		end else begin
			ex_hold <= 1'b0;
		end
	endtask

	// Present one instruction until the DUT takes it, then record its result
	task automatic issue(input opstage_pkg::op_t i_op, input opstage_pkg::reg_idx_t i_rd,
		input opstage_pkg::reg_idx_t i_ra, input opstage_pkg::reg_idx_t i_rb,
		input opstage_pkg::word_t i_imm, input logic i_use_imm);
		logic taken;
		opstage_pkg::word_t b;
		opstage_pkg::word_t res;
		instr_valid <= 1'b1;
		op <= i_op;
		rd <= i_rd;
		ra <= i_ra;
		rb <= i_rb;
		imm <= i_imm;
		use_imm <= i_use_imm;
		taken = 1'b0;
		stall_cycles = 0;
		while (!taken) begin
			// stall only moves on rising edges
			@(negedge clk);
			taken = !stall;
			tick();
			if (!taken) begin
				stall_cycles++;
				if (stall_cycles > WAIT_LIMIT) begin
					abort_run("Timeout: instruction held off by stall for too long");
				end
			end
		end
		b = i_use_imm ? i_imm : model_read(i_rb);
		res = alu_ref(i_op, model_read(i_ra), b);
		if (i_rd != '0) begin
			model_rf[i_rd] = res;
		end
		exp_rd_q.push_back(i_rd);
		exp_data_q.push_back(res);
		issued++;
	endtask

	// Bubble cycles, junk fields must never retire
	task automatic gap(input int cycles);
		instr_valid <= 1'b0;
		op <= opstage_pkg::op_t'($urandom_range(5, 0));
		ra <= opstage_pkg::reg_idx_t'($urandom_range(15, 0));
		rb <= opstage_pkg::reg_idx_t'($urandom_range(15, 0));
		imm <= $urandom();
		repeat (cycles) tick();
	endtask

	// Narrow register range keeps hazards frequent
	task automatic issue_random();
		opstage_pkg::op_t r_op;
		opstage_pkg::reg_idx_t r_rd;
		opstage_pkg::reg_idx_t r_ra;
		opstage_pkg::reg_idx_t r_rb;
		opstage_pkg::word_t r_imm;
		logic r_use;
		r_op = opstage_pkg::op_t'($urandom_range(5, 0));
		r_rd = opstage_pkg::reg_idx_t'($urandom_range(7, 0));
		r_ra = opstage_pkg::reg_idx_t'($urandom_range(7, 0));
		r_rb = opstage_pkg::reg_idx_t'($urandom_range(7, 0));
		r_imm = $urandom();
		r_use = ($urandom_range(3, 0) == 0);
		issue(r_op, r_rd, r_ra, r_rb, r_imm, r_use);
	endtask

	task automatic random_run(input int count);
		for (int i = 0; i < count; i++) begin
			issue_random();
			if ($urandom_range(2, 0) == 0) begin
				gap($urandom_range(3, 1));
			end
		end
	endtask

	// Wait until every recorded result has retired
	task automatic drain();
		int waited;
		hold_mode = 1'b0;
		instr_valid <= 1'b0;
		ex_hold <= 1'b0;
		waited = 0;
		while (exp_rd_q.size() != 0) begin
			tick();
			waited++;
			if (waited > WAIT_LIMIT) begin
				abort_run("Timeout: results still missing from writeback");
			end
		end
	endtask

	task automatic report(input int num, input string name, input int errs_before,
		input int count);
		$display("[%0d] %s: %0d instructions, %0d errors", num, name, count,
			errors - errs_before);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Writeback compare
	//////////////////////////////////////////////////////////////////////
	always @(negedge clk) begin : compare_wb
		opstage_pkg::reg_idx_t e_rd;
		opstage_pkg::word_t e_data;
		if (!rst && wb_valid) begin
			assert (exp_rd_q.size() != 0) else begin
				$display("Writeback pulse for r%0d with no instruction outstanding", wb_rd);
				errors++;
			end
			if (exp_rd_q.size() != 0) begin
				e_rd = exp_rd_q.pop_front();
				e_data = exp_data_q.pop_front();
				checks++;
				assert (wb_rd == e_rd) else begin
					$display("Mismatch wb_rd: got %h expected %h", wb_rd, e_rd);
					errors++;
				end
				assert (wb_data == e_data) else begin
					$display("Mismatch wb_data: got %h expected %h", wb_data, e_data);
					errors++;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		int seed;
		int errs_before;
		int count_before;
		int waited;
		opstage_pkg::reg_idx_t prev;
		opstage_pkg::reg_idx_t prev2;
		opstage_pkg::reg_idx_t dst;
		seed = $urandom(57260);
		clk = 1'b0;
		rst = 1'b1;
		instr_valid = 1'b0;
		op = opstage_pkg::OP_ADD;
		rd = '0;
		ra = '0;
		rb = '0;
		imm = '0;
		use_imm = 1'b0;
		ex_hold = 1'b0;
		hold_mode = 1'b0;
		errors = 0;
		checks = 0;
		issued = 0;
		stall_cycles = 0;
		foreach (model_rf[i]) begin
			model_rf[i] = '0;
		end
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		tick();

		// Reset state, all registers read back zero
		errs_before = errors;
		count_before = issued;
		@(negedge clk);
		assert (stall == 1'b0) else begin
			$display("Mismatch stall: got %h expected %h", stall, 1'b0);
			errors++;
		end
		assert (wb_valid == 1'b0) else begin
			$display("Mismatch wb_valid: got %h expected %h", wb_valid, 1'b0);
			errors++;
		end
		tick();
		// Each register ORed with r0 into itself
		for (int i = 1; i < opstage_pkg::REG_N; i++) begin
			issue(opstage_pkg::OP_OR, opstage_pkg::reg_idx_t'(i), opstage_pkg::reg_idx_t'(i),
				'0, '0, 1'b0);
		end
		drain();
		report(1, "reset state", errs_before, issued - count_before);

		// Immediates, registers loaded first
		errs_before = errors;
		count_before = issued;
		for (int i = 1; i < opstage_pkg::REG_N; i++) begin
			issue(opstage_pkg::OP_ADD, opstage_pkg::reg_idx_t'(i), '0, '0, $urandom(), 1'b1);
		end
		for (int k = 0; k < 6; k++) begin
			for (int j = 0; j < 4; j++) begin
				dst = opstage_pkg::reg_idx_t'($urandom_range(15, 1));
				prev = opstage_pkg::reg_idx_t'($urandom_range(15, 0));
				issue(opstage_pkg::op_t'(k), dst, prev, '0, $urandom(), 1'b1);
			end
		end
		drain();
		report(2, "immediate ALU ops", errs_before, issued - count_before);

		// Chains through EX and WB forwarding, every eighth result lands in r0
		errs_before = errors;
		count_before = issued;
		prev = 4'd1;
		prev2 = 4'd2;
		for (int i = 0; i < 40; i++) begin
			if (i % 8 == 7) begin
				dst = '0;
			end else begin
				dst = opstage_pkg::reg_idx_t'($urandom_range(15, 1));
			end
			issue(opstage_pkg::op_t'($urandom_range(4, 0)), dst, prev, prev2, '0, 1'b0);
			prev2 = prev;
			prev = dst;
		end
		drain();
		report(3, "forwarding", errs_before, issued - count_before);

		// Multiply with a dependent op right behind it
		errs_before = errors;
		count_before = issued;
		for (int i = 0; i < 8; i++) begin
			dst = opstage_pkg::reg_idx_t'($urandom_range(15, 1));
			prev = opstage_pkg::reg_idx_t'($urandom_range(15, 1));
			prev2 = opstage_pkg::reg_idx_t'($urandom_range(15, 1));
			issue(opstage_pkg::OP_MUL, dst, prev, prev2, '0, 1'b0);
			prev = opstage_pkg::reg_idx_t'($urandom_range(15, 1));
			issue(opstage_pkg::op_t'($urandom_range(5, 0)), prev, dst, dst, '0, 1'b0);
			assert (stall_cycles == MUL_CYCLES - 1) else begin
				$display("Mismatch stall cycles: got %h expected %h", stall_cycles,
					MUL_CYCLES - 1);
				errors++;
			end
		end
		drain();
		report(4, "multiply", errs_before, issued - count_before);

		// Bubbles mixed with back-pressure
		errs_before = errors;
		count_before = issued;
		hold_mode = 1'b1;
		random_run(120);
		drain();
		report(5, "freezes", errs_before, issued - count_before);

		// Long random mix, nothing may be left over
		errs_before = errors;
		count_before = issued;
		hold_mode = 1'b1;
		random_run(300);
		hold_mode = 1'b0;
		instr_valid <= 1'b0;
		ex_hold <= 1'b0;
		// Idle until the queue empties or the limit runs out
		waited = 0;
		while ((exp_rd_q.size() != 0) && (waited < WAIT_LIMIT)) begin
			tick();
			waited++;
		end
		repeat (4) tick();
		assert (exp_rd_q.size() == 0) else begin
			$display("Results still missing from writeback after the random run");
			errors++;
		end
		report(6, "random mix", errs_before, issued - count_before);

		$display("Summary: %0d instructions, %0d checks, %0d errors", issued, checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
common/opstage_pkg.sv
src/reg_file.sv
operands/forward_sel.sv
operands/operand_mux.sv
src/pipe_ctrl.sv
src/exec_unit.sv
src/opstage_top.sv
tests/tb_opstage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the operand stage testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_opstage -f list.f --Mdir obj_dir -o sim_opstage
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_opstage 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^Test OK$"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
